// File: src/riscvCompactPkg.sv
package riscvCompactPkg;

  localparam int InstructionWidth = 32;
  localparam int HalfwordWidth = 16;

  // Low two bits of an instruction
  typedef enum logic [1:0] {
    quadrantZero = 2'b00,
    quadrantOne  = 2'b01,
    quadrantTwo  = 2'b10,
    fullWidth    = 2'b11    // Not compressed
  } compactQuadrant;

  // Major opcodes produced by the expander
  typedef enum logic [6:0] {
    opLoad  = 7'b0000011,
    opStore = 7'b0100011,
    opImm   = 7'b0010011,
    opReg   = 7'b0110011
  } baseOpcode;

  typedef enum logic [2:0] {
    passThrough,
    expanded,
    illegal,
    ignored,          // FP and RV64/RV128 forms
    notImplemented
  } expandStatus;

endpackage

// File: src/compactInstructionExpander.sv
`timescale 1ns/1ns

module compactInstructionExpander (
  input  logic [riscvCompactPkg::InstructionWidth-1:0] rawInstruction,
  output logic [riscvCompactPkg::InstructionWidth-1:0] expandedInstruction,
  output riscvCompactPkg::expandStatus                 status
);

  import riscvCompactPkg::*;

  logic [HalfwordWidth-1:0] compact;
  compactQuadrant           quadrant;
  logic [2:0]               func3;
  logic                     func4;
  logic [4:0]               wideRsLeft;
  logic [4:0]               wideRsRight;
  logic [4:0]               expandedRsLeft;
  logic [4:0]               expandedRsRight;
  logic [11:0]              wordOffset;
  logic [11:0]              signedImmediate;

  assign compact = rawInstruction[HalfwordWidth-1:0];
  assign quadrant = compactQuadrant'(compact[1:0]);
  assign func3 = compact[15:13];
  assign func4 = compact[12];

  assign wideRsLeft = compact[11:7];
  assign wideRsRight = compact[6:2];
  assign expandedRsLeft = {2'b01, compact[9:7]};    // x8 to x15
  assign expandedRsRight = {2'b01, compact[4:2]};

  // Unsigned, scaled by 4
  assign wordOffset = {5'b00000, compact[5], compact[12:10], compact[6], 2'b00};
  assign signedImmediate = {{7{compact[12]}}, compact[6:2]};

  always_comb begin
    expandedInstruction = '0;
    status = notImplemented;

    case (quadrant)
      quadrantZero: begin
        case (func3)
          3'b000: begin
            if (compact == '0) begin
              status = illegal;    // All zero
            end else begin
              status = notImplemented;    // C.ADDI4SPN
            end
          end
          3'b010: begin    // C.LW
            expandedInstruction = {wordOffset, expandedRsLeft, 3'b010, expandedRsRight,
                                   opLoad};
            status = expanded;
          end
          3'b100: begin
            status = illegal;    // Reserved
          end
          3'b110: begin    // C.SW
            expandedInstruction = {wordOffset[11:5], expandedRsRight, expandedRsLeft, 3'b010,
                                   wordOffset[4:0], opStore};
            status = expanded;
          end
          default: begin
            status = ignored;    // FP and wide loads/stores
          end
        endcase
      end

      quadrantOne: begin
        case (func3)
          3'b000: begin    // C.NOP and C.ADDI
            expandedInstruction = {signedImmediate, wideRsLeft, 3'b000, wideRsLeft, opImm};
            status = expanded;
          end
          3'b100: begin
            case (compact[11:10])
              2'b10: begin    // C.ANDI
                expandedInstruction = {signedImmediate, expandedRsLeft, 3'b111, expandedRsLeft,
                                       opImm};
                status = expanded;
              end
              2'b11: begin
                case ({func4, compact[6:5]})
                  3'b000: begin    // C.SUB
                    expandedInstruction = {7'b0100000, expandedRsRight, expandedRsLeft, 3'b000,
                                           expandedRsLeft, opReg};
                    status = expanded;
                  end
                  3'b001: begin    // C.XOR
                    expandedInstruction = {7'b0000000, expandedRsRight, expandedRsLeft, 3'b100,
                                           expandedRsLeft, opReg};
                    status = expanded;
                  end
                  3'b010: begin    // C.OR
                    expandedInstruction = {7'b0000000, expandedRsRight, expandedRsLeft, 3'b110,
                                           expandedRsLeft, opReg};
                    status = expanded;
                  end
                  3'b011: begin    // C.AND
                    expandedInstruction = {7'b0000000, expandedRsRight, expandedRsLeft, 3'b111,
                                           expandedRsLeft, opReg};
                    status = expanded;
                  end
                  3'b100, 3'b101: begin
                    status = ignored;    // C.SUBW, C.ADDW
                  end
                  default: begin
                    status = illegal;
                  end
                endcase
              end
              default: begin
                status = notImplemented;    // Shifts by immediate
              end
            endcase
          end
          default: begin
            status = notImplemented;    // Jumps, branches, C.LI, C.LUI
          end
        endcase
      end

      quadrantTwo: begin
        case (func3)
          3'b001, 3'b011, 3'b101, 3'b111: begin
            status = ignored;
          end
          3'b100: begin
            if (func4 && wideRsRight != 5'd0) begin    // C.ADD
              expandedInstruction = {7'b0000000, wideRsRight, wideRsLeft, 3'b000, wideRsLeft,
                                     opReg};
              status = expanded;
            end else begin
              status = notImplemented;    // C.JR, C.MV, C.JALR, C.EBREAK
            end
          end
          default: begin
            status = notImplemented;
          end
        endcase
      end

      fullWidth: begin
        expandedInstruction = rawInstruction;
        status = passThrough;
      end

      default: begin
        status = illegal;
      end
    endcase
  end

endmodule

// File: src/instructionFetcher.sv
`timescale 1ns/1ns

module instructionFetcher #(
  parameter int          AddressWidth = 8,
  parameter int unsigned ResetVector  = 0
) (
  input  logic                                         clock,
  input  logic                                         reset,
  input  logic                                         fetchEnable,
  input  logic                                         stall,
  input  logic                                         fetchDone,
  input  logic [riscvCompactPkg::InstructionWidth-1:0] fetchReadData,
  output logic                                         fetchRequest,
  output logic [AddressWidth-1:0]                      fetchAddress,
  output logic [riscvCompactPkg::InstructionWidth-1:0] rawInstruction,
  output logic [AddressWidth+1:0]                      instructionAddress,
  output logic                                         instructionValid,
  output logic                                         isCompressed
);

  import riscvCompactPkg::*;

  typedef enum logic [1:0] {
    idle,
    fetchLow,
    fetchHigh,    // Second word of a straddling instruction
    holding
  } fetchState;

  fetchState                state;
  logic [AddressWidth+1:0]  programCounter;    // Byte address
  logic [AddressWidth-1:0]  wordAddress;
  logic [HalfwordWidth-1:0] upperHalfBuffer;
  logic [HalfwordWidth-1:0] selectedHalf;
  logic                     selectedIsFull;

  assign wordAddress = programCounter[AddressWidth+1:2];
  assign instructionAddress = programCounter;    // Moves only when leaving holding

  assign fetchRequest = (state == fetchLow) || (state == fetchHigh);
  assign fetchAddress = (state == fetchHigh) ? wordAddress + AddressWidth'(1) : wordAddress;

  assign selectedHalf = programCounter[1] ? fetchReadData[InstructionWidth-1:HalfwordWidth]
                                          : fetchReadData[HalfwordWidth-1:0];
  assign selectedIsFull = compactQuadrant'(selectedHalf[1:0]) == fullWidth;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= idle;
      programCounter <= (AddressWidth + 2)'(ResetVector);
      instructionValid <= 1'b0;
    end else begin
      case (state)
        idle: begin
          if (fetchEnable) begin
            state <= fetchLow;
          end
        end
        fetchLow: begin
          if (fetchDone) begin
            if (selectedIsFull && programCounter[1]) begin
              state <= fetchHigh;    // Upper half continues in next word
            end else begin
              state <= holding;
              instructionValid <= 1'b1;
            end
          end
        end
        fetchHigh: begin
          if (fetchDone) begin
            state <= holding;
            instructionValid <= 1'b1;
          end
        end
        holding: begin
          if (!stall) begin
            instructionValid <= 1'b0;
            programCounter <= programCounter + (isCompressed ? (AddressWidth + 2)'(2)
                                                             : (AddressWidth + 2)'(4));
            state <= fetchEnable ? fetchLow : idle;
          end
        end
        default: begin
          state <= idle;
        end
      endcase
    end
  end

  // Output register and straddle buffer
  always_ff @(posedge clock) begin
    if (fetchDone && state == fetchLow) begin
      if (!selectedIsFull) begin
        rawInstruction <= {{(InstructionWidth - HalfwordWidth){1'b0}}, selectedHalf};
        isCompressed <= 1'b1;
      end else if (!programCounter[1]) begin
        rawInstruction <= fetchReadData;
        isCompressed <= 1'b0;
      end else begin
        upperHalfBuffer <= selectedHalf;
      end
    end
    if (fetchDone && state == fetchHigh) begin
      rawInstruction <= {fetchReadData[HalfwordWidth-1:0], upperHalfBuffer};
      isCompressed <= 1'b0;
    end
  end

endmodule

// File: src/memoryArbiter.sv
`timescale 1ns/1ns

module memoryArbiter #(
  parameter int AddressWidth = 8
) (
  input  logic                                         clock,
  input  logic                                         reset,
  input  logic                                         dataRequest,
  input  logic                                         dataWrite,
  input  logic [AddressWidth-1:0]                      dataAddress,
  input  logic [riscvCompactPkg::InstructionWidth-1:0] dataWriteData,
  input  logic                                         fetchRequest,
  input  logic [AddressWidth-1:0]                      fetchAddress,
  input  logic [riscvCompactPkg::InstructionWidth-1:0] memoryReadData,
  output logic [riscvCompactPkg::InstructionWidth-1:0] dataReadData,
  output logic                                         dataDone,
  output logic [riscvCompactPkg::InstructionWidth-1:0] fetchReadData,
  output logic                                         fetchDone,
  output logic                                         memoryEnable,
  output logic                                         memoryWrite,
  output logic [AddressWidth-1:0]                      memoryAddress,
  output logic [riscvCompactPkg::InstructionWidth-1:0] memoryWriteData
);

  logic dataGrant;
  logic fetchGrant;
  logic dataInFlight;     // Owner of the access now returning
  logic fetchInFlight;

  // No regrant in the done cycle, the request fields are still the old ones
  assign dataGrant = dataRequest && !dataInFlight;
  assign fetchGrant = fetchRequest && !fetchInFlight && !dataGrant;

  assign memoryEnable = dataGrant || fetchGrant;
  assign memoryWrite = dataGrant && dataWrite;
  assign memoryAddress = dataGrant ? dataAddress : fetchAddress;
  assign memoryWriteData = dataWriteData;    // Fetcher only reads

  always_ff @(posedge clock) begin
    if (reset) begin
      dataInFlight <= 1'b0;
      fetchInFlight <= 1'b0;
    end else begin
      dataInFlight <= dataGrant;
      fetchInFlight <= fetchGrant;
    end
  end

  assign dataDone = dataInFlight;
  assign fetchDone = fetchInFlight;
  assign dataReadData = dataInFlight ? memoryReadData : '0;
  assign fetchReadData = fetchInFlight ? memoryReadData : '0;

endmodule

// File: src/unifiedMemory.sv
`timescale 1ns/1ns

module unifiedMemory #(
  parameter int AddressWidth = 8
) (
  input  logic                                         clock,
  input  logic                                         memoryEnable,
  input  logic                                         memoryWrite,
  input  logic [AddressWidth-1:0]                      memoryAddress,
  input  logic [riscvCompactPkg::InstructionWidth-1:0] memoryWriteData,
  output logic [riscvCompactPkg::InstructionWidth-1:0] memoryReadData
);

  import riscvCompactPkg::*;

  localparam int Depth = 1 << AddressWidth;

  logic [InstructionWidth-1:0] memoryArray [Depth];    // Program and data

  always_ff @(posedge clock) begin
    if (memoryEnable) begin
      if (memoryWrite) begin
        memoryArray[memoryAddress] <= memoryWriteData;
      end else begin
        memoryReadData <= memoryArray[memoryAddress];    // One cycle latency
      end
    end
  end

endmodule

// File: src/instructionFrontEnd.sv
`timescale 1ns/1ns

module instructionFrontEnd #(
  parameter int          AddressWidth = 8,
  parameter int unsigned ResetVector  = 0
) (
  input  logic                                         clock,
  input  logic                                         reset,
  input  logic                                         fetchEnable,
  input  logic                                         stall,
  input  logic                                         dataRequest,
  input  logic                                         dataWrite,
  input  logic [AddressWidth-1:0]                      dataAddress,
  input  logic [riscvCompactPkg::InstructionWidth-1:0] dataWriteData,
  output logic [riscvCompactPkg::InstructionWidth-1:0] dataReadData,
  output logic                                         dataDone,
  output logic                                         instructionValid,
  output logic [AddressWidth+1:0]                      instructionAddress,
  output logic [riscvCompactPkg::InstructionWidth-1:0] instruction,
  output riscvCompactPkg::expandStatus                 instructionStatus,
  output logic                                         isCompressed
);

  import riscvCompactPkg::*;

  logic                        fetchRequest;
  logic [AddressWidth-1:0]     fetchAddress;
  logic                        fetchDone;
  logic [InstructionWidth-1:0] fetchReadData;

  logic                        memoryEnable;
  logic                        memoryWrite;
  logic [AddressWidth-1:0]     memoryAddress;
  logic [InstructionWidth-1:0] memoryWriteData;
  logic [InstructionWidth-1:0] memoryReadData;

  logic [InstructionWidth-1:0] rawInstruction;

  memoryArbiter #(
    .AddressWidth(AddressWidth)
  ) u_memoryArbiter (
    .clock          (clock),
    .reset          (reset),
    .dataRequest    (dataRequest),
    .dataWrite      (dataWrite),
    .dataAddress    (dataAddress),
    .dataWriteData  (dataWriteData),
    .fetchRequest   (fetchRequest),
    .fetchAddress   (fetchAddress),
    .memoryReadData (memoryReadData),
    .dataReadData   (dataReadData),
    .dataDone       (dataDone),
    .fetchReadData  (fetchReadData),
    .fetchDone      (fetchDone),
    .memoryEnable   (memoryEnable),
    .memoryWrite    (memoryWrite),
    .memoryAddress  (memoryAddress),
    .memoryWriteData(memoryWriteData)
  );

  unifiedMemory #(
    .AddressWidth(AddressWidth)
  ) u_unifiedMemory (
    .clock          (clock),
    .memoryEnable   (memoryEnable),
    .memoryWrite    (memoryWrite),
    .memoryAddress  (memoryAddress),
    .memoryWriteData(memoryWriteData),
    .memoryReadData (memoryReadData)
  );

  instructionFetcher #(
    .AddressWidth(AddressWidth),
    .ResetVector (ResetVector)
  ) u_instructionFetcher (
    .clock             (clock),
    .reset             (reset),
    .fetchEnable       (fetchEnable),
    .stall             (stall),
    .fetchDone         (fetchDone),
    .fetchReadData     (fetchReadData),
    .fetchRequest      (fetchRequest),
    .fetchAddress      (fetchAddress),
    .rawInstruction    (rawInstruction),
    .instructionAddress(instructionAddress),
    .instructionValid  (instructionValid),
    .isCompressed      (isCompressed)
  );

  // Same cycle as the output register
  compactInstructionExpander u_compactInstructionExpander (
    .rawInstruction     (rawInstruction),
    .expandedInstruction(instruction),
    .status             (instructionStatus)
  );

endmodule

// File: bench/instructionFrontEnd_assertions.sv
`timescale 1ns/1ns

module instructionFrontEnd_assertions #(
  parameter int          AddressWidth = 8,
  parameter int unsigned ResetVector  = 0
) (
  input logic                                         clock,
  input logic                                         reset,
  input logic                                         fetchEnable,
  input logic                                         stall,
  input logic                                         dataRequest,
  input logic                                         dataDone,
  input logic                                         memoryEnable,
  input logic                                         instructionValid,
  input logic [AddressWidth+1:0]                      instructionAddress,
  input logic [riscvCompactPkg::InstructionWidth-1:0] instruction,
  input logic [riscvCompactPkg::InstructionWidth-1:0] rawInstruction,
  input riscvCompactPkg::expandStatus                 instructionStatus,
  input logic                                         isCompressed
);

  import riscvCompactPkg::*;

  int                      failureCount = 0;
  logic                    fetchSeen;      // fetchEnable has been high since reset
  logic [AddressWidth+1:0] nextAddress;    // Where the next instruction must sit

  always_ff @(posedge clock) begin
    if (reset) begin
      fetchSeen <= 1'b0;
      nextAddress <= (AddressWidth + 2)'(ResetVector);
    end else begin
      if (fetchEnable) begin
        fetchSeen <= 1'b1;
      end
      if (instructionValid && !stall) begin    // Instruction leaves the output register
        nextAddress <= instructionAddress + (isCompressed ? (AddressWidth + 2)'(2)
                                                          : (AddressWidth + 2)'(4));
      end
    end
  end

  idleBeforeEnable: assert property (@(posedge clock) disable iff (reset)
    !fetchSeen |-> !instructionValid && (!memoryEnable || dataRequest))
    else begin
      failureCount++;
      $error("front end active before fetchEnable");
    end

  doneNeedsRequest: assert property (@(posedge clock) disable iff (reset)
    dataDone |-> $past(dataRequest))
    else begin
      failureCount++;
      $error("dataDone without a data request");
    end

  addressStep: assert property (@(posedge clock) disable iff (reset)
    $rose(instructionValid) |-> instructionAddress == nextAddress)
    else begin
      failureCount++;
      $error("instruction address did not advance by the instruction size");
    end

  fullWidthUnchanged: assert property (@(posedge clock) disable iff (reset)
    instructionValid && rawInstruction[1:0] == 2'b11
      |-> instruction == rawInstruction && instructionStatus == passThrough)
    else begin
      failureCount++;
      $error("32-bit instruction was altered");
    end

  zeroWhenUnsupported: assert property (@(posedge clock) disable iff (reset)
    instructionValid && instructionStatus != expanded && instructionStatus != passThrough
      |-> instruction == '0)
    else begin
      failureCount++;
      $error("unsupported encoding produced a nonzero word");
    end

  stallHolds: assert property (@(posedge clock) disable iff (reset)
    instructionValid && stall
      |=> instructionValid && $stable(instruction) && $stable(instructionAddress))
    else begin
      failureCount++;
      $error("output changed under stall");
    end

endmodule

bind instructionFrontEnd instructionFrontEnd_assertions #(
  .AddressWidth(AddressWidth),
  .ResetVector (ResetVector)
) u_frontEndAssertions (.*);

// File: bench/instructionFrontEndTb.sv
`timescale 1ns/1ns

module instructionFrontEndTb;

  import riscvCompactPkg::*;

  localparam int AddressWidth = 8;
  localparam int ResetVector = 0;
  localparam int Timeout = 200;
  localparam int ProgramWords = 8;
  localparam int ScratchAddress = 100;

  logic                    clock;
  logic                    reset;
  logic                    fetchEnable;
  logic                    stall;
  logic                    dataRequest;
  logic                    dataWrite;
  logic [AddressWidth-1:0] dataAddress;
  logic [31:0]             dataWriteData;
  logic [31:0]             dataReadData;
  logic                    dataDone;
  logic                    instructionValid;
  logic [AddressWidth+1:0] instructionAddress;
  logic [31:0]             instruction;
  expandStatus             instructionStatus;
  logic                    isCompressed;

  logic [15:0] programHalves [2*ProgramWords];
  logic [31:0] memoryModel [1<<AddressWidth];
  int          expectedAddress [$];
  logic [31:0] expectedWord [$];
  expandStatus expectedStatus [$];
  logic        expectedCompressed [$];
  int          halfIndex;
  integer      seed;
  int          errorCount;
  int          testsRun;
  int          testsFailed;

  instructionFrontEnd #(
    .AddressWidth(AddressWidth),
    .ResetVector (ResetVector)
  ) u_instructionFrontEnd (.*);

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  function automatic int totalErrors();
    return errorCount + u_instructionFrontEnd.u_frontEndAssertions.failureCount;
  endfunction

  task automatic reportError(input string message);
    $display("[ERROR] %0t: %s", $time, message);
    errorCount++;
  endtask

  task automatic abortRun(input string reason);
    $display("%s", reason);
    $display("test failed");
    $finish;
  endtask

  task automatic finishTest(input string name, input int errorsBefore);
    testsRun++;
    if (totalErrors() > errorsBefore) begin
      testsFailed++;
      $display("%s: FAIL", name);
    end else begin
      $display("%s: ok", name);
    end
  endtask

  function automatic logic [4:0] wide(input logic [2:0] r);
    return {2'b01, r};    // x8 to x15
  endfunction

  task automatic addCompact(input logic [15:0] compact, input logic [31:0] word,
                            input expandStatus status);
    expectedAddress.push_back(ResetVector + 2 * halfIndex);
    expectedWord.push_back(word);
    expectedStatus.push_back(status);
    expectedCompressed.push_back(1'b1);
    programHalves[halfIndex] = compact;
    halfIndex++;
  endtask

  task automatic addFull(input logic [31:0] word);
    expectedAddress.push_back(ResetVector + 2 * halfIndex);
    expectedWord.push_back(word);
    expectedStatus.push_back(passThrough);
    expectedCompressed.push_back(1'b0);
    programHalves[halfIndex] = word[15:0];
    programHalves[halfIndex+1] = word[31:16];
    halfIndex += 2;
  endtask

  task automatic addArith(input logic [1:0] op, input logic [2:0] funct3,
                          input logic [6:0] funct7);
    logic [2:0] r1;
    logic [2:0] r2;
    r1 = $random(seed);
    r2 = $random(seed);
    addCompact({6'b100011, r1, op, r2, 2'b01},
               {funct7, wide(r2), wide(r1), funct3, wide(r1), 7'b0110011}, expanded);
  endtask

  task automatic buildProgram();
    logic [4:0]  rd;
    logic [4:0]  rs;
    logic [5:0]  imm;
    logic [2:0]  ra;
    logic [2:0]  rb;
    logic [6:0]  off;
    rd = $random(seed);
    imm = $random(seed);
    addCompact({3'b000, imm[5], rd, imm[4:0], 2'b01},    // C.ADDI
               {{6{imm[5]}}, imm, rd, 3'b000, rd, 7'b0010011}, expanded);
    ra = $random(seed);
    rb = $random(seed);
    off = {$random(seed), 2'b00};
    addCompact({3'b010, off[5:3], ra, off[2], off[6], rb, 2'b00},    // C.LW
               {5'b0, off, wide(ra), 3'b010, wide(rb), 7'b0000011}, expanded);
    addFull(32'h00A30293);
    off = {$random(seed), 2'b00};
    addCompact({3'b110, off[5:3], ra, off[2], off[6], rb, 2'b00},    // C.SW
               {5'b0, off[6:5], wide(rb), wide(ra), 3'b010, off[4:0], 7'b0100011},
               expanded);
    addFull(32'h40B50533);    // Straddles words 2 and 3
    addArith(2'b00, 3'b000, 7'b0100000);
    addArith(2'b01, 3'b100, 7'b0000000);
    addArith(2'b10, 3'b110, 7'b0000000);
    addArith(2'b11, 3'b111, 7'b0000000);
    imm = $random(seed);
    addCompact({3'b100, imm[5], 2'b10, ra, imm[4:0], 2'b01},    // C.ANDI
               {{6{imm[5]}}, imm, wide(ra), 3'b111, wide(ra), 7'b0010011}, expanded);
    rs = $random(seed);
    if (rs == 5'd0) begin
      rs = 5'd1;
    end
    addCompact({4'b1001, rd, rs, 2'b10}, {7'b0, rs, rd, 3'b000, rd, 7'b0110011}, expanded);
    addCompact(16'h0000, 32'h0, illegal);
    addCompact({3'b001, 11'($random(seed)), 2'b00}, 32'h0, ignored);    // C.FLD
    addCompact({3'b101, 11'($random(seed)), 2'b01}, 32'h0, notImplemented);    // C.J
  endtask

  task automatic dataAccess(input logic write, input logic [AddressWidth-1:0] address,
                            input logic [31:0] writeValue, output logic [31:0] readValue);
    int waited;
    @(posedge clock);
    dataRequest <= 1'b1;
    dataWrite <= write;
    dataAddress <= address;
    dataWriteData <= writeValue;
    waited = 0;
    @(posedge clock);
    while (!dataDone && waited < Timeout) begin
      @(posedge clock);
      waited++;
    end
    if (!dataDone) begin
      abortRun("Data port never answered with dataDone");
    end else begin
      readValue = dataReadData;
      dataRequest <= 1'b0;
      @(posedge clock);
      if (dataDone) begin
        reportError($sformatf("second dataDone pulse for address %0d", address));
      end
    end
  endtask

  task automatic checkRead(input logic [AddressWidth-1:0] address);
    logic [31:0] value;
    dataAccess(1'b0, address, 32'h0, value);
    if (value !== memoryModel[address]) begin
      reportError($sformatf("read %0d got %h, expected %h", address, value,
                            memoryModel[address]));
    end
  endtask

  task automatic runFetch();
    int          waited;
    int          holdCycles;
    expandStatus wantStatus;
    for (int i = 0; i < expectedWord.size(); i++) begin
      wantStatus = expectedStatus[i];
      waited = 0;
      @(posedge clock);
      while (!instructionValid && waited < Timeout) begin
        @(posedge clock);
        waited++;
      end
      if (!instructionValid) begin
        abortRun("Fetcher never produced the next valid instruction");
      end else begin
        if (instructionAddress !== expectedAddress[i] || instruction !== expectedWord[i] ||
            instructionStatus !== wantStatus || isCompressed !== expectedCompressed[i]) begin
          reportError($sformatf("at %0d got %h %s compressed %0b, expected at %0d %h %s %0b",
                                instructionAddress, instruction, instructionStatus.name(),
                                isCompressed, expectedAddress[i], expectedWord[i],
                                wantStatus.name(), expectedCompressed[i]));
        end
        holdCycles = $random(seed) & 3;
        repeat (holdCycles) @(posedge clock);
        stall <= 1'b0;
        if (i == expectedWord.size() - 1) begin
          fetchEnable <= 1'b0;    // Stop at the end of the program
        end
        @(posedge clock);
        stall <= 1'b1;
      end
    end
  endtask

  initial begin
    int mark;
    logic [31:0] unused;
    seed = 89;
    reset = 1'b1;
    fetchEnable = 1'b0;
    stall = 1'b1;
    dataRequest = 1'b0;
    dataWrite = 1'b0;
    dataAddress = '0;
    dataWriteData = '0;
    errorCount = 0;
    testsRun = 0;
    testsFailed = 0;
    halfIndex = 0;
    buildProgram();
    repeat (8) @(posedge clock);
    reset <= 1'b0;

    mark = totalErrors();
    repeat (4) @(posedge clock);
    if (instructionValid || dataDone) begin
      reportError("front end not idle after reset");
    end
    finishTest("reset and idle", mark);

    mark = totalErrors();
    for (int w = 0; w < ProgramWords; w++) begin
      memoryModel[w] = {programHalves[2*w+1], programHalves[2*w]};
      dataAccess(1'b1, w, memoryModel[w], unused);
    end
    memoryModel[ScratchAddress] = 32'h5A5A0000 ^ $random(seed);
    dataAccess(1'b1, ScratchAddress, memoryModel[ScratchAddress], unused);
    finishTest("program load", mark);

    mark = totalErrors();
    @(posedge clock);
    fetchEnable <= 1'b1;
    fork
      runFetch();
      begin
        for (int w = 0; w < ProgramWords; w++) begin
          checkRead(w);
        end
        memoryModel[ScratchAddress] = ~memoryModel[ScratchAddress];
        dataAccess(1'b1, ScratchAddress, memoryModel[ScratchAddress], unused);
        checkRead(ScratchAddress);
      end
    join
    finishTest("fetch, expansion and data reads", mark);

    $display("tests %0d, failed %0d, errors %0d", testsRun, testsFailed, totalErrors());
    if (totalErrors() == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// File: compile.f
src/riscvCompactPkg.sv
src/compactInstructionExpander.sv
src/instructionFetcher.sv
src/memoryArbiter.sv
src/unifiedMemory.sv
src/instructionFrontEnd.sv
bench/instructionFrontEnd_assertions.sv
bench/instructionFrontEndTb.sv
